// File: sram_pkg.sv
`default_nettype none

package sram_pkg;

    // word address and data widths of the external chip
    localparam int addr_w = 20;
    localparam int data_w = 32;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } sram_op_e;

    // one access as a master hands it over
    typedef struct packed {
        sram_op_e            op;
        logic [addr_w-1:0]   addr;
        logic [data_w-1:0]   wdata;
    } sram_req_t;

    // returned together with the done pulse
    typedef struct packed {
        logic [data_w-1:0]   rdata;
    } sram_rsp_t;

    // 0 is the fetch port, 1 the data port
    typedef logic port_id_t;

endpackage

`default_nettype wire

// File: sram_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module sram_ctrl #(
    parameter int addr_w      = sram_pkg::addr_w,
    parameter int data_w      = sram_pkg::data_w,
    parameter int wait_cycles = 2
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 start,
    input  sram_pkg::sram_req_t req,
    input  wire  [data_w-1:0]   sram_dq_in,
    output logic                busy,
    output logic                done,
    output sram_pkg::sram_rsp_t rsp,
    output logic [addr_w-1:0]   sram_addr,
    output logic                sram_ce_n,
    output logic                sram_we_n,
    output logic                sram_oe_n,
    output logic [data_w-1:0]   sram_dq_out,
    output logic                sram_dq_oe
);

    // wide enough to count up to wait_cycles-1
    localparam int cnt_w = (wait_cycles > 1) ? $clog2(wait_cycles) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(wait_cycles - 1);

    typedef enum logic [2:0] {
        st_idle     = 3'd0,
        st_wr_setup = 3'd1,
        st_wr_wait  = 3'd2,
        st_wr_hold  = 3'd3,
        st_rd_wait  = 3'd4,
        st_rd_end   = 3'd5
    } state_e;

    state_e              state;
    logic [cnt_w-1:0]    cnt;
    sram_pkg::sram_req_t req_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            cnt   <= '0;
            done  <= 1'b0;
        end else begin
            // done is one cycle behind the last active state
            done <= (state == st_wr_hold) || (state == st_rd_end);
            case (state)
                st_idle: begin
                    cnt <= '0;
                    if (start) begin
                        if (req.op == sram_pkg::op_write) begin
                            state <= st_wr_setup;
                        end else begin
                            state <= st_rd_wait;
                        end
                    end
                end
                st_wr_setup, st_wr_wait: begin
                    if (cnt == cnt_last) begin
                        state <= st_wr_hold;
                    end else begin
                        cnt   <= cnt + 1'b1;
                        state <= st_wr_wait;
                    end
                end
                st_wr_hold: begin
                    state <= st_idle;
                end
                st_rd_wait: begin
                    if (cnt == cnt_last) begin
                        state <= st_rd_end;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_rd_end: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // payload captured once per access
    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            req_q <= req;
        end
    end

    // sample at the end of the last cycle with oe_n low
    always_ff @(posedge clk) begin
        if (state == st_rd_end) begin
            rsp.rdata <= sram_dq_in;
        end
    end

    assign busy        = (state != st_idle);
    assign sram_addr   = req_q.addr;
    assign sram_dq_out = req_q.wdata;
    assign sram_ce_n   = (state == st_idle);
    assign sram_we_n   = !((state == st_wr_setup) || (state == st_wr_wait));
    assign sram_oe_n   = !((state == st_rd_wait) || (state == st_rd_end));
    // hold cycle keeps the bus driven after we_n rises
    assign sram_dq_oe  = (state == st_wr_setup) || (state == st_wr_wait) ||
                         (state == st_wr_hold);

    // the arbiter must never issue into a running access
    a_start_idle: assert property (
        @(posedge clk) disable iff (rst) start |-> !busy
    );

endmodule

`default_nettype wire

// File: sram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module sram_arbiter (
    input  wire                  clk,
    input  wire                  rst,
    input  wire  [1:0]           pend,
    input  sram_pkg::sram_req_t  preq0,
    input  sram_pkg::sram_req_t  preq1,
    input  wire                  busy,
    input  wire                  done,
    input  sram_pkg::sram_rsp_t  rsp,
    output logic                 start,
    output sram_pkg::sram_req_t  creq,
    output logic [1:0]           fin,
    output sram_pkg::sram_rsp_t  frsp
);

    sram_pkg::port_id_t prio;
    sram_pkg::port_id_t owner;
    sram_pkg::port_id_t winner;
    logic               inflight;
    logic               grant;

    // priority bit only matters when both ports want the chip
    always_comb begin
        if (pend[0] && pend[1]) begin
            winner = prio;
        end else if (pend[1]) begin
            winner = 1'b1;
        end else begin
            winner = 1'b0;
        end
    end

    assign grant = !inflight && !busy && (|pend);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start    <= 1'b0;
            inflight <= 1'b0;
            prio     <= 1'b0;
            owner    <= 1'b0;
        end else begin
            start <= 1'b0;
            if (done) begin
                inflight <= 1'b0;
            end
            if (grant) begin
                start    <= 1'b1;
                inflight <= 1'b1;
                owner    <= winner;
                prio     <= ~winner;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            creq <= winner ? preq1 : preq0;
        end
    end

    // done goes back only to the port that owns the access
    assign fin  = done ? (owner ? 2'b10 : 2'b01) : 2'b00;
    assign frsp = rsp;

    // a finish only reaches a port that is still waiting
    a_fin_pending: assert property (
        @(posedge clk) disable iff (rst) (fin & ~pend) == 2'b00
    );

endmodule

`default_nettype wire

// File: sram_req_port.sv
`timescale 1ns/1ps
`default_nettype none

module sram_req_port (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          req,
    input  sram_pkg::sram_req_t          req_data,
    input  wire                          fin,
    input  sram_pkg::sram_rsp_t          frsp,
    output logic                         ack,
    output logic [sram_pkg::data_w-1:0]  rdata,
    output logic                         pend,
    output sram_pkg::sram_req_t          preq
);

    typedef enum logic [1:0] {
        ph_idle    = 2'd0,
        ph_pending = 2'd1,
        ph_acked   = 2'd2
    } phase_e;

    phase_e phase;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= ph_idle;
        end else begin
            case (phase)
                ph_idle: begin
                    if (req) begin
                        phase <= ph_pending;
                    end
                end
                ph_pending: begin
                    if (fin) begin
                        phase <= ph_acked;
                    end
                end
                ph_acked: begin
                    // master holding req keeps the port here
                    if (!req) begin
                        phase <= ph_idle;
                    end
                end
                default: begin
                    phase <= ph_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == ph_idle && req) begin
            preq <= req_data;
        end
        if (phase == ph_pending && fin) begin
            rdata <= frsp.rdata;
        end
    end

    assign pend = (phase == ph_pending);
    assign ack  = (phase == ph_acked);

    // master must hold its request until it is acknowledged
    a_req_stable: assert property (
        @(posedge clk) disable iff (rst) (req && !ack) ##1 (req && !ack) |-> $stable(req_data)
    );

endmodule

`default_nettype wire

// File: sram_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module sram_subsys_top #(
    parameter int addr_w      = sram_pkg::addr_w,
    parameter int data_w      = sram_pkg::data_w,
    parameter int wait_cycles = 2
) (
    input  wire                  clk,
    input  wire                  rst,
    // fetch master
    input  wire                  f_req,
    input  sram_pkg::sram_req_t  f_req_data,
    output logic                 f_ack,
    output logic [data_w-1:0]    f_rdata,
    // data master
    input  wire                  d_req,
    input  sram_pkg::sram_req_t  d_req_data,
    output logic                 d_ack,
    output logic [data_w-1:0]    d_rdata,
    // chip pins
    output logic [addr_w-1:0]    sram_addr,
    output logic                 sram_ce_n,
    output logic                 sram_we_n,
    output logic                 sram_oe_n,
    output logic [data_w-1:0]    sram_dq_out,
    output logic                 sram_dq_oe,
    input  wire  [data_w-1:0]    sram_dq_in
);

    logic [1:0]          pend;
    logic [1:0]          fin;
    sram_pkg::sram_req_t preq0;
    sram_pkg::sram_req_t preq1;
    sram_pkg::sram_req_t creq;
    sram_pkg::sram_rsp_t frsp;
    sram_pkg::sram_rsp_t rsp;
    logic                start;
    logic                busy;
    logic                done;

    sram_req_port u_fetch_port (
        .clk      (clk),
        .rst      (rst),
        .req      (f_req),
        .req_data (f_req_data),
        .fin      (fin[0]),
        .frsp     (frsp),
        .ack      (f_ack),
        .rdata    (f_rdata),
        .pend     (pend[0]),
        .preq     (preq0)
    );

    sram_req_port u_data_port (
        .clk      (clk),
        .rst      (rst),
        .req      (d_req),
        .req_data (d_req_data),
        .fin      (fin[1]),
        .frsp     (frsp),
        .ack      (d_ack),
        .rdata    (d_rdata),
        .pend     (pend[1]),
        .preq     (preq1)
    );

    sram_arbiter u_arbiter (
        .clk   (clk),
        .rst   (rst),
        .pend  (pend),
        .preq0 (preq0),
        .preq1 (preq1),
        .busy  (busy),
        .done  (done),
        .rsp   (rsp),
        .start (start),
        .creq  (creq),
        .fin   (fin),
        .frsp  (frsp)
    );

    sram_ctrl #(
        .addr_w      (addr_w),
        .data_w      (data_w),
        .wait_cycles (wait_cycles)
    ) u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .req         (creq),
        .sram_dq_in  (sram_dq_in),
        .busy        (busy),
        .done        (done),
        .rsp         (rsp),
        .sram_addr   (sram_addr),
        .sram_ce_n   (sram_ce_n),
        .sram_we_n   (sram_we_n),
        .sram_oe_n   (sram_oe_n),
        .sram_dq_out (sram_dq_out),
        .sram_dq_oe  (sram_dq_oe)
    );

endmodule

`default_nettype wire

// File: tb_sram_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sram_model #(
    parameter int addr_w = sram_pkg::addr_w,
    parameter int data_w = sram_pkg::data_w
) (
    input  wire                clk,
    input  wire                rst,
    input  wire  [addr_w-1:0]  addr,
    input  wire                ce_n,
    input  wire                we_n,
    input  wire                oe_n,
    input  wire  [data_w-1:0]  dq_out,
    input  wire                dq_oe,
    output logic [data_w-1:0]  dq_in,
    output int                 pin_errors
);

    logic [data_w-1:0] mem [0:(1<<addr_w)-1];
    logic [addr_w-1:0] addr_q;
    logic              ce_q;

    // bus resolver, controller drives on writes and the chip on reads
    assign dq_in = dq_oe ? dq_out : ((!ce_n && !oe_n) ? mem[addr] : '0);

    // word lands at the end of the write strobe
    always @(posedge we_n) begin
        if (!ce_n) begin
            mem[addr] <= dq_out;
        end
    end

    always @(posedge clk or posedge rst) begin
        int found;
        if (rst) begin
            ce_q       <= 1'b1;
            addr_q     <= '0;
            pin_errors <= 0;
        end else begin
            found = 0;
            if (!we_n && !oe_n) begin
                $display("pin rule broken at %0t: we_n and oe_n low together", $time);
                found++;
            end
            if (dq_oe && !oe_n) begin
                $display("pin rule broken at %0t: controller drives dq while oe_n is low", $time);
                found++;
            end
            if (!ce_n && !we_n && !dq_oe) begin
                $display("pin rule broken at %0t: write strobe with dq not driven", $time);
                found++;
            end
            // address must hold for the whole access
            if (!ce_n && !ce_q && addr != addr_q) begin
                $display("pin rule broken at %0t: address moved while ce_n low", $time);
                found++;
            end
            pin_errors <= pin_errors + found;
            ce_q       <= ce_n;
            addr_q     <= addr;
        end
    end

endmodule

`default_nettype wire

// File: tb_sram_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sram_subsys;

    localparam int addr_w      = sram_pkg::addr_w;
    localparam int data_w      = sram_pkg::data_w;
    localparam int wait_cycles = 2;
    localparam int max_lines   = 64;
    // req to ack with the chip otherwise idle
    localparam int lat_single  = wait_cycles + 5;

    logic                clk;
    logic                rst;
    logic                f_req;
    sram_pkg::sram_req_t f_req_data;
    logic                f_ack;
    logic [data_w-1:0]   f_rdata;
    logic                d_req;
    sram_pkg::sram_req_t d_req_data;
    logic                d_ack;
    logic [data_w-1:0]   d_rdata;
    logic [addr_w-1:0]   sram_addr;
    logic                sram_ce_n;
    logic                sram_we_n;
    logic                sram_oe_n;
    logic [data_w-1:0]   sram_dq_out;
    logic                sram_dq_oe;
    logic [data_w-1:0]   sram_dq_in;
    int                  pin_errors;

    // six words per golden line
    logic [31:0] gold [0:6*max_lines-1];
    int          cyc = 0;
    int          limit = 0;
    int          errors = 0;
    int          prio = 0;
    // per port state of the group in flight, index 0 fetch and 1 data
    logic        act [2];
    logic        rd [2];
    logic [31:0] exp_data [2];
    int          rise [2];

    sram_subsys_top #(
        .addr_w      (addr_w),
        .data_w      (data_w),
        .wait_cycles (wait_cycles)
    ) i_sram_subsys_top (
        .clk         (clk),
        .rst         (rst),
        .f_req       (f_req),
        .f_req_data  (f_req_data),
        .f_ack       (f_ack),
        .f_rdata     (f_rdata),
        .d_req       (d_req),
        .d_req_data  (d_req_data),
        .d_ack       (d_ack),
        .d_rdata     (d_rdata),
        .sram_addr   (sram_addr),
        .sram_ce_n   (sram_ce_n),
        .sram_we_n   (sram_we_n),
        .sram_oe_n   (sram_oe_n),
        .sram_dq_out (sram_dq_out),
        .sram_dq_oe  (sram_dq_oe),
        .sram_dq_in  (sram_dq_in)
    );

    tb_sram_model #(
        .addr_w (addr_w),
        .data_w (data_w)
    ) u_sram (
        .clk        (clk),
        .rst        (rst),
        .addr       (sram_addr),
        .ce_n       (sram_ce_n),
        .we_n       (sram_we_n),
        .oe_n       (sram_oe_n),
        .dq_out     (sram_dq_out),
        .dq_oe      (sram_dq_oe),
        .dq_in      (sram_dq_in),
        .pin_errors (pin_errors)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    always @(posedge clk) begin
        if (limit > 0 && cyc >= limit) begin
            $display("timeout at cycle %0d: an access never completed", cyc);
            $display("Test failed");
            $finish;
        end
    end

    function automatic string test_name(input int g, input int p);
        return $sformatf("group %0d %s %s", g, (p == 1) ? "data" : "fetch",
                         rd[p] ? "read" : "write");
    endfunction

    // put one golden line on its master
    task automatic load_line(input int i);
        int                  p;
        sram_pkg::sram_req_t r;
        p           = gold[i*6+1];
        r.op        = gold[i*6+2][0] ? sram_pkg::op_write : sram_pkg::op_read;
        r.addr      = gold[i*6+3][addr_w-1:0];
        r.wdata     = gold[i*6+4];
        act[p]      = 1'b1;
        rd[p]       = (r.op == sram_pkg::op_read);
        exp_data[p] = gold[i*6+5];
        if (p == 1) begin
            d_req_data = r;
            d_req      = 1'b1;
        end else begin
            f_req_data = r;
            f_req      = 1'b1;
        end
    endtask

    task automatic wait_acks(input int t0, input int g);
        while ((act[0] && rise[0] < 0) || (act[1] && rise[1] < 0)) begin
            @(negedge clk);
            if (act[0] && rise[0] < 0 && f_ack) begin
                rise[0] = cyc - t0;
                if (rd[0] && f_rdata !== exp_data[0]) begin
                    $display("Error %s: expected %h, actual %h", test_name(g, 0),
                             exp_data[0], f_rdata);
                    errors++;
                end
            end
            if (act[1] && rise[1] < 0 && d_ack) begin
                rise[1] = cyc - t0;
                if (rd[1] && d_rdata !== exp_data[1]) begin
                    $display("Error %s: expected %h, actual %h", test_name(g, 1),
                             exp_data[1], d_rdata);
                    errors++;
                end
            end
        end
    endtask

    // ack order and latency against the round-robin rule
    task automatic check_group(input int g);
        int first;
        int got;
        int p;
        if (act[0] && act[1]) begin
            first = prio;
            got   = (rise[0] < rise[1]) ? 0 : 1;
            if (got != first) begin
                $display("Error group %0d ack order: expected port %0d first, actual port %0d",
                         g, first, got);
                errors++;
            end
            if (rise[first] != lat_single) begin
                $display("Error group %0d winner latency: expected %0d, actual %0d",
                         g, lat_single, rise[first]);
                errors++;
            end
            if (rise[1-first] < rise[first] + wait_cycles + 2) begin
                $display("Error group %0d second latency: expected at least %0d, actual %0d",
                         g, rise[first] + wait_cycles + 2, rise[1-first]);
                errors++;
            end
            // second grant hands priority back to the winner
            prio = first;
        end else begin
            p = act[1] ? 1 : 0;
            if (rise[p] != lat_single) begin
                $display("Error group %0d latency: expected %0d, actual %0d",
                         g, lat_single, rise[p]);
                errors++;
            end
            prio = 1 - p;
        end
    endtask

    initial begin
        int k;
        int idx;
        int g;
        int last;
        int groups;
        int t0;
        rst        = 1'b1;
        f_req      = 1'b0;
        f_req_data = '0;
        d_req      = 1'b0;
        d_req_data = '0;
        for (k = 0; k < 6*max_lines; k++) begin
            gold[k] = 32'hff;
        end
        $readmemh("sram_golden.txt", gold);
        groups = 0;
        last   = -1;
        for (k = 0; k < max_lines && gold[k*6] != 32'hff; k++) begin
            g = gold[k*6];
            if (g != last) begin
                groups++;
            end
            last = g;
        end
        if (groups == 0) begin
            $display("golden file sram_golden.txt holds no accesses");
            errors++;
        end
        limit = groups * 4 * (wait_cycles + 8);
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        if (sram_ce_n !== 1'b1 || sram_we_n !== 1'b1 || sram_oe_n !== 1'b1) begin
            $display("Error reset pins ce_n/we_n/oe_n: expected 111, actual %b%b%b",
                     sram_ce_n, sram_we_n, sram_oe_n);
            errors++;
        end
        if (f_ack !== 1'b0 || d_ack !== 1'b0) begin
            $display("Error reset acks f/d: expected 00, actual %b%b", f_ack, d_ack);
            errors++;
        end
        idx = 0;
        while (idx < max_lines && gold[idx*6] != 32'hff) begin
            g       = gold[idx*6];
            act[0]  = 1'b0;
            act[1]  = 1'b0;
            rise[0] = -1;
            rise[1] = -1;
            @(posedge clk);
            #1;
            while (idx < max_lines && gold[idx*6] == 32'(g)) begin
                load_line(idx);
                idx++;
            end
            t0 = cyc;
            wait_acks(t0, g);
            check_group(g);
            @(posedge clk);
            #1;
            f_req = 1'b0;
            d_req = 1'b0;
            while (f_ack || d_ack) begin
                @(negedge clk);
            end
        end
        @(negedge clk);
        $display("closing counts: %0d access errors, %0d pin errors", errors, pin_errors);
        if (errors == 0 && pin_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sram_golden.txt
// columns: group port op address wdata expected_rdata, all hex
// port 0 fetch, 1 data; op 0 read, 1 write; group ff ends the list
01 0 1 00200 33334444 00000000
02 0 0 00200 00000000 33334444
03 1 1 00100 11112222 00000000
04 1 0 00100 00000000 11112222
05 0 1 00300 aaaa5555 00000000
05 1 1 00301 5555aaaa 00000000
06 0 0 00300 00000000 aaaa5555
07 0 0 00301 00000000 5555aaaa
07 1 0 00300 00000000 aaaa5555
08 1 1 00300 0badf00d 00000000
09 0 0 00300 00000000 0badf00d
0a 0 1 fffff 89abcdef 00000000
0a 1 1 00000 01234567 00000000
0b 0 0 00000 00000000 01234567
0b 1 0 fffff 00000000 89abcdef
0c 1 0 00301 00000000 5555aaaa
ff 0 0 00000 00000000 00000000

// File: compile.f
sram_pkg.sv
sram_ctrl.sv
sram_arbiter.sv
sram_req_port.sv
sram_subsys_top.sv
tb_sram_model.sv
tb_sram_subsys.sv

// File: run_sim.sh
#!/bin/sh
# build and run the SRAM subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f compile.f --top-module tb_sram_subsys -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test completed successfully$" "$log"; then
    exit 0
else
    echo "pass message not found in $log"
    exit 1
fi
